//--- common/g729_pkg.sv
package g729_pkg;

	//////////////////////////////////////////////////
	// Data widths and constants
	//////////////////////////////////////////////////

	localparam int WORD16 = 16;
	localparam int WORD32 = 32;

	// Cosine table and slope entries
	localparam int TABLE_DEPTH = 64;

	localparam logic [WORD32-1:0] ROUND_CONST = 32'h0000_8000;

	localparam int LSF_SHIFT = 3;
	localparam int IND_SHIFT = 8;

	// Scratch address width carried in the memory structs
	localparam int MEM_ADDR_WIDTH = 12;

	//////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		IDLE,
		CHECK,
		FETCH,
		COMPARE,
		DEC_IND,
		INTERP,
		SHIFT,
		STORE,
		NEXT
	} lsp_state_e;

	//////////////////////////////////////////////////
	// Request and response bundles
	//////////////////////////////////////////////////

	// Operand pairs, one per basic operator
	typedef struct packed {
		logic [WORD16-1:0] add_a;
		logic [WORD16-1:0] add_b;
		logic [WORD16-1:0] sub_a;
		logic [WORD16-1:0] sub_b;
		logic [WORD16-1:0] shl_var;
		logic [WORD16-1:0] shl_amt;
		logic [WORD32-1:0] l_add_a;
		logic [WORD32-1:0] l_add_b;
		logic [WORD16-1:0] l_mult_a;
		logic [WORD16-1:0] l_mult_b;
	} arith_req_t;

	typedef struct packed {
		logic [WORD16-1:0] add;
		logic [WORD16-1:0] sub;
		logic [WORD16-1:0] shl;
		logic [WORD32-1:0] l_add;
		logic [WORD32-1:0] l_mult;
	} arith_rsp_t;

	typedef struct packed {
		logic              start;
		logic [WORD32-1:0] value;
		logic [WORD16-1:0] shift;
	} lshl_req_t;

	typedef struct packed {
		logic              done;
		logic [WORD32-1:0] result;
	} lshl_rsp_t;

	// Engine side of the scratch RAM
	typedef struct packed {
		logic [MEM_ADDR_WIDTH-1:0] read_addr;
		logic [MEM_ADDR_WIDTH-1:0] write_addr;
		logic [WORD32-1:0]         write_data;
		logic                      write_en;
	} mem_req_t;

	typedef struct packed {
		logic                      we;
		logic [MEM_ADDR_WIDTH-1:0] addr;
		logic [WORD32-1:0]         wdata;
	} host_req_t;

endpackage

//--- logic/basic_ops.sv
`timescale 1ns/1ps

module basic_ops
	import g729_pkg::*;
(
	input  arith_req_t arith_req,
	output arith_rsp_t arith_rsp
);

	logic signed [WORD16:0] add_wide;
	logic signed [WORD16:0] sub_wide;

	// Clamp to the 16-bit range
	function automatic logic [WORD16-1:0] sat16(input logic signed [WORD16:0] x);
		if (x > 17'sd32767) begin
			return 16'h7fff;
		end
		if (x < -17'sd32768) begin
			return 16'h8000;
		end
		return x[WORD16-1:0];
	endfunction

	function automatic logic [WORD16-1:0] shl16(input logic [WORD16-1:0] var1,
			input logic [WORD16-1:0] var2);
		logic signed [WORD16:0]   amt;
		logic signed [WORD16:0]   neg_amt;
		logic signed [WORD32-1:0] wide;
		amt     = $signed({var2[WORD16-1], var2});
		neg_amt = -amt;
		wide    = $signed({{WORD16{var1[WORD16-1]}}, var1});
		// Negative count shifts right
		if (amt < 0) begin
			if (neg_amt >= 17'sd15) begin
				return {WORD16{var1[WORD16-1]}};
			end
			wide = wide >>> neg_amt[3:0];
			return wide[WORD16-1:0];
		end
		if (amt > 17'sd15) begin
			if (var1 == '0) begin
				return '0;
			end
			return var1[WORD16-1] ? 16'h8000 : 16'h7fff;
		end
		wide = wide <<< amt[3:0];
		// Overflow when the result no longer fits in 16 bits
		if (wide != {{WORD16{wide[WORD16-1]}}, wide[WORD16-1:0]}) begin
			return var1[WORD16-1] ? 16'h8000 : 16'h7fff;
		end
		return wide[WORD16-1:0];
	endfunction

	function automatic logic [WORD32-1:0] l_add32(input logic [WORD32-1:0] a,
			input logic [WORD32-1:0] b);
		logic [WORD32-1:0] sum;
		sum = a + b;
		if (a[WORD32-1] == b[WORD32-1] && sum[WORD32-1] != a[WORD32-1]) begin
			return a[WORD32-1] ? 32'h8000_0000 : 32'h7fff_ffff;
		end
		return sum;
	endfunction

	function automatic logic [WORD32-1:0] l_mult32(input logic [WORD16-1:0] a,
			input logic [WORD16-1:0] b);
		logic signed [WORD32-1:0] prod;
		prod = $signed(a) * $signed(b);
		// -32768 * -32768 is the only overflow
		if (prod == 32'sh4000_0000) begin
			return 32'h7fff_ffff;
		end
		return prod <<< 1;
	endfunction

	assign add_wide = $signed({arith_req.add_a[WORD16-1], arith_req.add_a})
		+ $signed({arith_req.add_b[WORD16-1], arith_req.add_b});
	assign sub_wide = $signed({arith_req.sub_a[WORD16-1], arith_req.sub_a})
		- $signed({arith_req.sub_b[WORD16-1], arith_req.sub_b});

	assign arith_rsp.add    = sat16(add_wide);
	assign arith_rsp.sub    = sat16(sub_wide);
	assign arith_rsp.shl    = shl16(arith_req.shl_var, arith_req.shl_amt);
	assign arith_rsp.l_add  = l_add32(arith_req.l_add_a, arith_req.l_add_b);
	assign arith_rsp.l_mult = l_mult32(arith_req.l_mult_a, arith_req.l_mult_b);

endmodule

//--- logic/l_shl_unit.sv
`timescale 1ns/1ps

module l_shl_unit
	import g729_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  lshl_req_t lshl_req,
	output lshl_rsp_t lshl_rsp
);

	logic [WORD32-1:0] value_q;
	logic [WORD16-1:0] count_q;
	logic              busy_q;

	// One bit left, sticks at the limit once saturated
	function automatic logic [WORD32-1:0] shl1(input logic [WORD32-1:0] v);
		if (v[WORD32-1] != v[WORD32-2]) begin
			return v[WORD32-1] ? 32'h8000_0000 : 32'h7fff_ffff;
		end
		return {v[WORD32-2:0], 1'b0};
	endfunction

	// First shift happens on the load edge
	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q  <= 1'b0;
			count_q <= '0;
		end else if (lshl_req.start) begin
			busy_q  <= 1'b1;
			count_q <= (lshl_req.shift == '0) ? '0 : lshl_req.shift - 1'b1;
		end else if (busy_q) begin
			if (count_q == '0) begin
				busy_q <= 1'b0;
			end else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lshl_req.start) begin
			value_q <= (lshl_req.shift == '0) ? lshl_req.value : shl1(lshl_req.value);
		end else if (busy_q && count_q != '0) begin
			value_q <= shl1(value_q);
		end
	end

	assign lshl_rsp.done   = busy_q && (count_q == '0);
	assign lshl_rsp.result = value_q;

endmodule

//--- logic/scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem
	import g729_pkg::*;
#(
	parameter int ADDR_WIDTH = 12
) (
	input  logic              clock,
	input  mem_req_t          mem_req,
	output logic [WORD32-1:0] mem_rdata,
	input  host_req_t         host_req,
	output logic [WORD32-1:0] host_rdata
);

	logic [WORD32-1:0] mem [2**ADDR_WIDTH];

	// Port A is the engine, port B the host
	// Host write lands last on an address collision
	always_ff @(posedge clock) begin
		if (mem_req.write_en) begin
			mem[mem_req.write_addr[ADDR_WIDTH-1:0]] <= mem_req.write_data;
		end
		if (host_req.we) begin
			mem[host_req.addr[ADDR_WIDTH-1:0]] <= host_req.wdata;
		end
		mem_rdata  <= mem[mem_req.read_addr[ADDR_WIDTH-1:0]];
		host_rdata <= mem[host_req.addr[ADDR_WIDTH-1:0]];
	end

endmodule

//--- logic/constant_rom.sv
`timescale 1ns/1ps

module constant_rom
	import g729_pkg::*;
(
	input  logic              clock,
	input  logic [5:0]        rom_index,
	output logic [WORD32-1:0] rom_data
);

	// Slope in the upper half, cosine table in the lower half
	logic [WORD32-1:0] rom [TABLE_DEPTH];

	initial begin
		$readmemh("logic/constant_rom.hex", rom);
	end

	always_ff @(posedge clock) begin
		rom_data <= rom[rom_index];
	end

endmodule

//--- lsp_lsf/lsp_lsf.sv
`timescale 1ns/1ps

module lsp_lsf
	import g729_pkg::*;
#(
	parameter int ORDER      = 10,
	parameter int ADDR_WIDTH = 12
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	output logic                  done,
	input  logic [ADDR_WIDTH-1:0] lsp_base,
	input  logic [ADDR_WIDTH-1:0] lsf_base,
	output mem_req_t              mem_req,
	input  logic [WORD32-1:0]     mem_rdata,
	output logic [5:0]            rom_index,
	input  logic [WORD32-1:0]     rom_data,
	output arith_req_t            arith_req,
	input  arith_rsp_t            arith_rsp,
	output lshl_req_t             lshl_req,
	input  lshl_rsp_t             lshl_rsp
);

	lsp_state_e state_q, state_d;

	// Coefficient index, goes to -1 when the run is over
	logic signed [4:0] i_q;
	logic [5:0]        ind_q;
	logic              shift_issued_q;

	logic [WORD16-1:0] diff_q;
	logic [WORD16-1:0] ind_shl_q;
	logic [WORD16-1:0] rounded_q;

	logic [WORD16-1:0] lsp_val;
	logic [WORD16-1:0] table_val;
	logic [WORD16-1:0] slope_val;

	assign lsp_val   = mem_rdata[WORD16-1:0];
	assign table_val = rom_data[WORD16-1:0];
	assign slope_val = rom_data[WORD32-1:WORD16];

	//////////////////////////////////////////////////
	// Operand routing
	//////////////////////////////////////////////////

	always_comb begin
		arith_req = '0;
		// lsf = add(round(...), shl(ind, 8))
		arith_req.add_a    = rounded_q;
		arith_req.add_b    = ind_shl_q;
		arith_req.shl_var  = {10'b0, ind_q};
		arith_req.shl_amt  = WORD16'(IND_SHIFT);
		arith_req.l_add_a  = lshl_rsp.result;
		arith_req.l_add_b  = ROUND_CONST;
		arith_req.l_mult_a = diff_q;
		arith_req.l_mult_b = slope_val;
		// Only the subtractor is shared between states
		case (state_q)
			COMPARE: begin
				arith_req.sub_a = table_val;
				arith_req.sub_b = lsp_val;
			end
			DEC_IND: begin
				arith_req.sub_a = {10'b0, ind_q};
				arith_req.sub_b = 16'd1;
			end
			INTERP: begin
				arith_req.sub_a = lsp_val;
				arith_req.sub_b = table_val;
			end
			NEXT: begin
				arith_req.sub_a = {{11{i_q[4]}}, i_q};
				arith_req.sub_b = 16'd1;
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// Next state and memory control
	//////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		done    = 1'b0;
		// Low 4 address bits select the coefficient
		mem_req.read_addr  = MEM_ADDR_WIDTH'({lsp_base[ADDR_WIDTH-1:4], i_q[3:0]});
		mem_req.write_addr = MEM_ADDR_WIDTH'({lsf_base[ADDR_WIDTH-1:4], i_q[3:0]});
		mem_req.write_data = {{WORD16{1'b0}}, arith_rsp.add};
		mem_req.write_en   = 1'b0;
		rom_index      = ind_q;
		lshl_req.start = 1'b0;
		lshl_req.value = arith_rsp.l_mult;
		lshl_req.shift = WORD16'(LSF_SHIFT);
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = CHECK;
				end
			end
			CHECK: begin
				if (i_q[4]) begin
					done    = 1'b1;
					state_d = IDLE;
				end else begin
					state_d = FETCH;
				end
			end
			// Wait for the ROM and scratch read data
			FETCH: state_d = COMPARE;
			COMPARE: begin
				// Entry 0 ends the search
				if (arith_rsp.sub[WORD16-1] && ind_q != 6'd0) begin
					state_d = DEC_IND;
				end else begin
					state_d = INTERP;
				end
			end
			DEC_IND: state_d = FETCH;
			INTERP: state_d = SHIFT;
			SHIFT: begin
				if (!shift_issued_q) begin
					lshl_req.start = 1'b1;
				end else if (lshl_rsp.done) begin
					state_d = STORE;
				end
			end
			STORE: begin
				mem_req.write_en = 1'b1;
				state_d          = NEXT;
			end
			NEXT: state_d = CHECK;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q        <= IDLE;
			i_q            <= 5'(ORDER - 1);
			ind_q          <= 6'(TABLE_DEPTH - 1);
			shift_issued_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Counters restart for the next run
			if (state_q == CHECK && i_q[4]) begin
				i_q   <= 5'(ORDER - 1);
				ind_q <= 6'(TABLE_DEPTH - 1);
			end
			if (state_q == DEC_IND) begin
				ind_q <= arith_rsp.sub[5:0];
			end
			if (state_q == NEXT) begin
				i_q <= arith_rsp.sub[4:0];
			end
			if (state_q == SHIFT && !shift_issued_q) begin
				shift_issued_q <= 1'b1;
			end else if (state_q == SHIFT && lshl_rsp.done) begin
				shift_issued_q <= 1'b0;
			end
		end
	end

	// Interpolation operands and the rounded product
	always_ff @(posedge clock) begin
		if (state_q == INTERP) begin
			diff_q    <= arith_rsp.sub;
			ind_shl_q <= arith_rsp.shl;
		end
		if (state_q == SHIFT && lshl_rsp.done) begin
			rounded_q <= arith_rsp.l_add[WORD32-1:WORD16];
		end
	end

endmodule

//--- logic/lsp_lsf_top.sv
`timescale 1ns/1ps

module lsp_lsf_top
	import g729_pkg::*;
#(
	parameter int ORDER      = 10,
	parameter int ADDR_WIDTH = 12
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	output logic                  done,
	input  logic [ADDR_WIDTH-1:0] lsp_base,
	input  logic [ADDR_WIDTH-1:0] lsf_base,
	input  host_req_t             host_req,
	output logic [WORD32-1:0]     host_rdata
);

	mem_req_t          mem_req;
	logic [WORD32-1:0] mem_rdata;
	logic [5:0]        rom_index;
	logic [WORD32-1:0] rom_data;
	arith_req_t        arith_req;
	arith_rsp_t        arith_rsp;
	lshl_req_t         lshl_req;
	lshl_rsp_t         lshl_rsp;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	lsp_lsf #(
		.ORDER      (ORDER),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_lsp_lsf (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.done      (done),
		.lsp_base  (lsp_base),
		.lsf_base  (lsf_base),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.rom_index (rom_index),
		.rom_data  (rom_data),
		.arith_req (arith_req),
		.arith_rsp (arith_rsp),
		.lshl_req  (lshl_req),
		.lshl_rsp  (lshl_rsp)
	);

	//////////////////////////////////////////////////
	// Arithmetic and memories
	//////////////////////////////////////////////////

	basic_ops u_basic_ops (
		.arith_req (arith_req),
		.arith_rsp (arith_rsp)
	);

	l_shl_unit u_l_shl_unit (
		.clock    (clock),
		.reset    (reset),
		.lshl_req (lshl_req),
		.lshl_rsp (lshl_rsp)
	);

	scratch_mem #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_scratch_mem (
		.clock      (clock),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.host_req   (host_req),
		.host_rdata (host_rdata)
	);

	constant_rom u_constant_rom (
		.clock     (clock),
		.rom_index (rom_index),
		.rom_data  (rom_data)
	);

endmodule

//--- tb/lsp_lsf_properties.sv
`timescale 1ns/1ps

module lsp_lsf_properties (
	input logic clock,
	input logic reset,
	input logic start,
	input logic done
);

	// Upper bound on one run, 10 coefficients and a full index sweep
	localparam int RUN_CYCLES = 2000;

	int   fail_count = 0;
	logic busy_q;
	logic started_q;

	// Tracks whether a run was accepted and is still open
	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q    <= 1'b0;
			started_q <= 1'b0;
		end else begin
			if (start) begin
				started_q <= 1'b1;
			end
			if (start && !busy_q) begin
				busy_q <= 1'b1;
			end else if (done) begin
				busy_q <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Start/done protocol
	//////////////////////////////////////////////////

	no_early_done: assert property (@(posedge clock) disable iff (reset)
		!started_q |-> !done)
		else begin
			fail_count++;
			$error("done raised before the first start");
		end

	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else begin
			fail_count++;
			$error("done held high for more than one cycle");
		end

	// Each pulse closes exactly one accepted start
	done_after_start: assert property (@(posedge clock) disable iff (reset)
		done |-> busy_q)
		else begin
			fail_count++;
			$error("done without an accepted start");
		end

	start_gives_done: assert property (@(posedge clock) disable iff (reset)
		(start && !busy_q) |-> ##[1:RUN_CYCLES] done)
		else begin
			fail_count++;
			$error("accepted start never completed");
		end

endmodule

bind lsp_lsf_top lsp_lsf_properties protocol_checks (
	.clock (clock),
	.reset (reset),
	.start (start),
	.done  (done)
);

//--- tb/lsp_lsf_tb.sv
`timescale 1ns/1ps

module lsp_lsf_tb
	import g729_pkg::*;
();

	localparam int ORDER      = 10;
	localparam int ADDR_WIDTH = 12;
	// Six random sets, two back-to-back runs and one extreme set
	localparam int RUNS        = 9;
	localparam int CYCLE_LIMIT = 16 + RUNS * (ORDER * 200 + 200);

	logic                  clock;
	logic                  reset;
	logic                  start;
	logic                  done;
	logic [ADDR_WIDTH-1:0] lsp_base;
	logic [ADDR_WIDTH-1:0] lsf_base;
	host_req_t             host_req;
	logic [WORD32-1:0]     host_rdata;

	logic [WORD32-1:0] rom_words [TABLE_DEPTH];
	int                table_val [TABLE_DEPTH];
	int                slope_val [TABLE_DEPTH];
	int                lsp_set [ORDER];
	int                lsf_model [ORDER];
	int                readback [ORDER];
	logic [31:0]       seed;
	int                value_errors = 0;
	int                cycle_count = 0;

	lsp_lsf_top #(
		.ORDER      (ORDER),
		.ADDR_WIDTH (ADDR_WIDTH)
	) DUT (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.done       (done),
		.lsp_base   (lsp_base),
		.lsf_base   (lsf_base),
		.host_req   (host_req),
		.host_rdata (host_rdata)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Reference arithmetic
	//////////////////////////////////////////////////

	function automatic int clamp16(input int x);
		if (x > 32767) begin
			return 32767;
		end
		return (x < -32768) ? -32768 : x;
	endfunction

	function automatic longint clamp32(input longint x);
		if (x > 64'sd2147483647) begin
			return 64'sd2147483647;
		end
		return (x < -64'sd2147483648) ? -64'sd2147483648 : x;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] coef_addr(input logic [ADDR_WIDTH-1:0] base,
			input int k);
		return {base[ADDR_WIDTH-1:4], 4'(k)};
	endfunction

	// Search down the table, then interpolate inside the segment
	task automatic compute_model;
		int     ind;
		int     diff;
		longint acc;
		ind = TABLE_DEPTH - 1;
		for (int i = ORDER - 1; i >= 0; i--) begin
			while (ind > 0 && clamp16(table_val[ind] - lsp_set[i]) < 0) begin
				ind--;
			end
			diff = clamp16(lsp_set[i] - table_val[ind]);
			acc  = clamp32(2 * longint'(diff) * longint'(slope_val[ind]));
			for (int s = 0; s < LSF_SHIFT; s++) begin
				acc = clamp32(acc * 2);
			end
			acc          = clamp32(acc + 32768) >>> 16;
			lsf_model[i] = clamp16(int'(acc) + ind * 256);
		end
	endtask

	// Cosines falling from about 32000 with at least 2000 between neighbours
	task automatic make_sorted_set;
		int value;
		seed  = xorshift(seed);
		value = 32000 - int'(seed % 2000);
		for (int k = 0; k < ORDER; k++) begin
			lsp_set[k] = value;
			seed       = xorshift(seed);
			value      = value - 2000 - int'(seed % 4500);
		end
	endtask

	//////////////////////////////////////////////////
	// Host port and handshake
	//////////////////////////////////////////////////

	task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		@(posedge clock);
		host_req.we    <= 1'b1;
		host_req.addr  <= addr;
		host_req.wdata <= data;
	endtask

	task automatic read_word(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		@(posedge clock);
		host_req.we   <= 1'b0;
		host_req.addr <= addr;
		@(posedge clock);
		@(negedge clock);
		data = host_rdata;
	endtask

	task automatic load_set(input logic [ADDR_WIDTH-1:0] src);
		for (int k = 0; k < ORDER; k++) begin
			write_word(coef_addr(src, k), {16'h0, 16'(lsp_set[k])});
		end
		@(posedge clock);
		host_req.we <= 1'b0;
	endtask

	task automatic run_engine(input logic [ADDR_WIDTH-1:0] src,
			input logic [ADDR_WIDTH-1:0] dst, input bit poke_busy);
		@(posedge clock);
		lsp_base <= src;
		lsf_base <= dst;
		start    <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		// A second start mid-run must be ignored
		if (poke_busy) begin
			repeat (5) @(posedge clock);
			start <= 1'b1;
			@(posedge clock);
			start <= 1'b0;
		end
		do begin
			@(posedge clock);
		end while (!done);
	endtask

	task automatic check_results(input logic [ADDR_WIDTH-1:0] dst);
		logic [31:0] got;
		for (int i = 0; i < ORDER; i++) begin
			read_word(coef_addr(dst, i), got);
			readback[i] = $signed(got[15:0]);
			assert (got === {16'h0, 16'(lsf_model[i])}) else begin
				value_errors++;
				$display("CHECK FAILED at %0t: lsf[%0d] at %h is %h, model %h", $time, i,
					coef_addr(dst, i), got, {16'h0, 16'(lsf_model[i])});
			end
		end
	endtask

	task automatic check_inputs(input logic [ADDR_WIDTH-1:0] src);
		logic [31:0] got;
		for (int k = 0; k < ORDER; k++) begin
			read_word(coef_addr(src, k), got);
			assert (got === {16'h0, 16'(lsp_set[k])}) else begin
				value_errors++;
				$display("CHECK FAILED at %0t: lsp[%0d] input word changed to %h",
					$time, k, got);
			end
		end
	endtask

	task automatic check_increasing;
		for (int i = 1; i < ORDER; i++) begin
			assert (readback[i] > readback[i-1]) else begin
				value_errors++;
				$display("CHECK FAILED at %0t: lsf[%0d]=%0d not above lsf[%0d]=%0d",
					$time, i, readback[i], i - 1, readback[i-1]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int protocol_errors;
		clock    = 1'b0;
		reset    = 1'b1;
		start    = 1'b0;
		lsp_base = '0;
		lsf_base = '0;
		host_req = '0;
		seed     = 32'd33;
		#1;
		// Own copy of the table and slope values
		$readmemh("logic/constant_rom.hex", rom_words);
		for (int k = 0; k < TABLE_DEPTH; k++) begin
			table_val[k] = $signed(rom_words[k][15:0]);
			slope_val[k] = $signed(rom_words[k][31:16]);
		end
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		for (int run = 0; run < 6; run++) begin
			make_sorted_set();
			compute_model();
			load_set(12'h100);
			run_engine(12'h100, 12'(12'h200 + run * 16), run == 2);
			check_results(12'(12'h200 + run * 16));
			check_increasing();
		end

		// Same input into two result areas back to back
		make_sorted_set();
		compute_model();
		load_set(12'h300);
		run_engine(12'h300, 12'h400, 1'b0);
		run_engine(12'h300, 12'h500, 1'b1);
		check_inputs(12'h300);
		check_results(12'h400);
		check_results(12'h500);

		// Full-scale values drive the sub, L_shl and L_add limits
		lsp_set = '{0, 32767, -32768, 12000, -32768, 32767, -32768, 32767, -32768, 25000};
		compute_model();
		load_set(12'h600);
		run_engine(12'h600, 12'h700, 1'b0);
		check_results(12'h700);

		repeat (4) @(posedge clock);
		protocol_errors = DUT.protocol_checks.fail_count;
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- logic/constant_rom.hex
// Columns: slope[31:16] cos_table[15:0], one word per index 0..63
96f97fff
dd947fd9
eb357f62
f11b7e9d
f45d7d8a
f6747c2a
f7df7a7d
f8ed7885
f9b87642
fa5673b6
fad670e3
fb3d6dca
fb946a6e
fbdd66d0
fc1a62f2
fc4e5ed7
fc7b5a82
fca355f6
fcc55134
fce34c40
fcfc471d
fd1241ce
fd263c57
fd3736ba
fd4530fc
fd512b1f
fd5b2528
fd641f1a
fd6a18f9
fd6f12c8
fd720c8c
fd740648
fd740000
fd72f9b8
fd6ff374
fd6aed38
fd64e707
fd5be0e6
fd51dad8
fd45d4e1
fd37cf04
fd26c946
fd12c3a9
fcfcbe32
fce3b8e3
fcc5b3c0
fca3aecc
fc7baa0a
fc4ea57e
fc1aa129
fbdd9d0e
fb949930
fb3d9592
fad69236
fa568f1d
f9b88c4a
f8ed89be
f7df877b
f6748583
f45d83d6
f11b8276
eb358163
dd94809e
96f98027

//--- filelist.f
common/g729_pkg.sv
logic/basic_ops.sv
logic/l_shl_unit.sv
logic/scratch_mem.sv
logic/constant_rom.sv
lsp_lsf/lsp_lsf.sv
logic/lsp_lsf_top.sv
tb/lsp_lsf_properties.sv
tb/lsp_lsf_tb.sv

//--- Bender.yml
package:
  name: lsp_lsf

sources:
  - common/g729_pkg.sv
  - logic/basic_ops.sv
  - logic/l_shl_unit.sv
  - logic/scratch_mem.sv
  - logic/constant_rom.sv
  - lsp_lsf/lsp_lsf.sv
  - logic/lsp_lsf_top.sv
  - target: test
    files:
      - tb/lsp_lsf_properties.sv
      - tb/lsp_lsf_tb.sv
